//--- hw/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath and register width
`define RV_XLEN 64

// instruction sram word address bits, 64 words of 32 bits
`define RV_IMEM_AW 6

`endif

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes of the supported subset, inst[6:0]
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,  // addi
        OP     = 7'b0110011,  // add sub and or xor
        LUI    = 7'b0110111,
        JAL    = 7'b1101111,
        BRANCH = 7'b1100011   // beq only
    } opcode_e;

    // alu selection from idu to exu
    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND    = 3'd2,
        OR     = 3'd3,
        XOR    = 3'd4,
        PASS_B = 3'd5   // lui passes the u-immediate
    } alu_op_e;

endpackage

//--- hw/rv_bus_pkg.sv
package rv_bus_pkg;

    // read response, axi encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // ifu fetch sequence, halt is kept as a separate flag
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ADDR = 2'd1,
        DATA = 2'd2,
        EXEC = 2'd3
    } fetch_state_e;

endpackage

//--- hw/inst_sram.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module inst_sram (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   load_we_i,
    input  logic [`RV_IMEM_AW-1:0] load_addr_i,
    input  logic [31:0]            load_data_i,
    input  logic                   ar_valid_i,
    input  logic [`RV_XLEN-1:0]    ar_addr_i,
    output logic                   ar_ready_o,
    input  logic                   r_ready_i,
    output logic                   r_valid_o,
    output logic [31:0]            r_data_o,
    output rv_bus_pkg::resp_e      r_resp_o
);

    logic [31:0]       mem [0:(1 << `RV_IMEM_AW)-1];
    logic              r_valid_q;
    logic [31:0]       r_data_q;
    rv_bus_pkg::resp_e r_resp_q;
    logic              in_range;

    // only the low 2^(aw+2) bytes are backed by memory
    assign in_range   = (ar_addr_i[`RV_XLEN-1:`RV_IMEM_AW+2] == '0);
    assign ar_ready_o = !r_valid_q;  // one read outstanding at most

    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem[load_addr_i] <= load_data_i;
        end
        if (ar_valid_i && ar_ready_o) begin
            r_data_q <= in_range ? mem[ar_addr_i[`RV_IMEM_AW+1:2]] : 32'd0;
            r_resp_q <= in_range ? rv_bus_pkg::OKAY : rv_bus_pkg::SLVERR;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            r_valid_q <= 1'b0;
        end else if (ar_valid_i && ar_ready_o) begin
            r_valid_q <= 1'b1;
        end else if (r_ready_i) begin
            r_valid_q <= 1'b0;  // held until the master takes it
        end
    end

    assign r_valid_o = r_valid_q;
    assign r_data_o  = r_data_q;
    assign r_resp_o  = r_resp_q;

endmodule

//--- hw/rv_ifu.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_ifu (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                start_i,
    input  logic                ar_ready_i,
    input  logic                r_valid_i,
    input  logic [31:0]         r_data_i,
    input  rv_bus_pkg::resp_e   r_resp_i,
    input  logic [`RV_XLEN-1:0] next_pc_i,
    input  logic                illegal_i,
    output logic                ar_valid_o,
    output logic [`RV_XLEN-1:0] ar_addr_o,
    output logic                r_ready_o,
    output logic                ex_valid_o,
    output logic [`RV_XLEN-1:0] pc_o,
    output logic [31:0]         inst_o,
    output logic                fault_o
);

    rv_bus_pkg::fetch_state_e state_q;
    logic [`RV_XLEN-1:0]      pc_q;
    logic [31:0]              inst_q;
    logic                     halt_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= rv_bus_pkg::IDLE;
            pc_q    <= '0;
            halt_q  <= 1'b0;
        end else begin
            case (state_q)
                rv_bus_pkg::IDLE: begin
                    if (start_i && !halt_q) state_q <= rv_bus_pkg::ADDR;
                end
                rv_bus_pkg::ADDR: begin
                    if (ar_ready_i) state_q <= rv_bus_pkg::DATA;
                end
                rv_bus_pkg::DATA: begin
                    if (r_valid_i) begin
                        if (r_resp_i != rv_bus_pkg::OKAY) begin
                            halt_q  <= 1'b1;  // bus error, pc keeps the bad address
                            state_q <= rv_bus_pkg::IDLE;
                        end else begin
                            state_q <= rv_bus_pkg::EXEC;
                        end
                    end
                end
                default: begin  // EXEC, always one cycle
                    if (illegal_i) begin
                        halt_q  <= 1'b1;
                        state_q <= rv_bus_pkg::IDLE;
                    end else begin
                        pc_q    <= next_pc_i;  // redirect or pc+4
                        state_q <= rv_bus_pkg::ADDR;
                    end
                end
            endcase
        end
    end

    // instruction holding register
    always_ff @(posedge clk_i) begin
        if (state_q == rv_bus_pkg::DATA && r_valid_i) inst_q <= r_data_i;
    end

    assign ar_valid_o = (state_q == rv_bus_pkg::ADDR);
    assign ar_addr_o  = pc_q;
    assign r_ready_o  = (state_q == rv_bus_pkg::DATA);
    assign ex_valid_o = (state_q == rv_bus_pkg::EXEC);
    assign pc_o       = pc_q;
    assign inst_o     = inst_q;
    assign fault_o    = halt_q;

endmodule

//--- hw/rv_idu.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_idu (
    input  logic [`RV_XLEN-1:0] pc_i,
    input  logic [31:0]         inst_i,
    output logic [4:0]          raddr1_o,
    output logic [4:0]          raddr2_o,
    input  logic [`RV_XLEN-1:0] rdata1_i,
    input  logic [`RV_XLEN-1:0] rdata2_i,
    output logic [`RV_XLEN-1:0] op1_o,
    output logic [`RV_XLEN-1:0] op2_o,
    output rv_isa_pkg::alu_op_e alu_op_o,
    input  logic [`RV_XLEN-1:0] alu_result_i,
    input  logic                alu_eq_i,
    output logic                rd_we_o,
    output logic [4:0]          rd_addr_o,
    output logic                is_jal_o,
    output logic [`RV_XLEN-1:0] next_pc_o,
    output logic                illegal_o
);

    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // immediates, all sign extended from inst[31]
    assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'd0};
    assign imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21],
                    1'b0};

    assign raddr1_o  = inst_i[19:15];
    assign raddr2_o  = inst_i[24:20];
    assign rd_addr_o = inst_i[11:7];

    always_comb begin
        op1_o     = rdata1_i;
        op2_o     = rdata2_i;
        alu_op_o  = rv_isa_pkg::ADD;
        rd_we_o   = 1'b0;
        is_jal_o  = 1'b0;
        next_pc_o = pc_i + 64'd4;
        illegal_o = 1'b0;
        case (rv_isa_pkg::opcode_e'(inst_i[6:0]))
            rv_isa_pkg::OP_IMM: begin
                op2_o     = imm_i;
                rd_we_o   = (funct3 == 3'b000);  // addi only
                illegal_o = (funct3 != 3'b000);
            end
            rv_isa_pkg::OP: begin
                rd_we_o = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op_o = rv_isa_pkg::ADD;
                    10'b0100000_000: alu_op_o = rv_isa_pkg::SUB;
                    10'b0000000_111: alu_op_o = rv_isa_pkg::AND;
                    10'b0000000_110: alu_op_o = rv_isa_pkg::OR;
                    10'b0000000_100: alu_op_o = rv_isa_pkg::XOR;
                    default: begin
                        rd_we_o   = 1'b0;
                        illegal_o = 1'b1;
                    end
                endcase
            end
            rv_isa_pkg::LUI: begin
                op2_o    = imm_u;
                alu_op_o = rv_isa_pkg::PASS_B;
                rd_we_o  = 1'b1;
            end
            rv_isa_pkg::JAL: begin
                op1_o     = pc_i;  // alu forms the target, link comes from the core
                op2_o     = imm_j;
                rd_we_o   = 1'b1;
                is_jal_o  = 1'b1;
                next_pc_o = alu_result_i;
            end
            rv_isa_pkg::BRANCH: begin
                alu_op_o  = rv_isa_pkg::SUB;
                illegal_o = (funct3 != 3'b000);  // beq only
                if (alu_eq_i) next_pc_o = pc_i + imm_b;
            end
            default: illegal_o = 1'b1;
        endcase
    end

endmodule

//--- hw/rv_exu.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_exu (
    input  logic [`RV_XLEN-1:0] op1_i,
    input  logic [`RV_XLEN-1:0] op2_i,
    input  rv_isa_pkg::alu_op_e alu_op_i,
    output logic [`RV_XLEN-1:0] result_o,
    output logic                eq_o
);

    always_comb begin
        case (alu_op_i)
            rv_isa_pkg::ADD:    result_o = op1_i + op2_i;
            rv_isa_pkg::SUB:    result_o = op1_i - op2_i;
            rv_isa_pkg::AND:    result_o = op1_i & op2_i;
            rv_isa_pkg::OR:     result_o = op1_i | op2_i;
            rv_isa_pkg::XOR:    result_o = op1_i ^ op2_i;
            rv_isa_pkg::PASS_B: result_o = op2_i;
            default:            result_o = '0;
        endcase
    end

    // branch compare, rs1 against rs2
    assign eq_o = (op1_i == op2_i);

endmodule

//--- hw/rv_regs.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_regs (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                we_i,
    input  logic [4:0]          waddr_i,
    input  logic [`RV_XLEN-1:0] wdata_i,
    input  logic [4:0]          raddr1_i,
    input  logic [4:0]          raddr2_i,
    output logic [`RV_XLEN-1:0] rdata1_o,
    output logic [`RV_XLEN-1:0] rdata2_o
);

    logic [`RV_XLEN-1:0] regs_q [1:31];  // x0 has no storage

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) regs_q[i] <= '0;
        end else if (we_i && waddr_i != 5'd0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write is seen on the next read only
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs_q[raddr2_i];

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   start_i,
    input  logic                   load_we_i,
    input  logic [`RV_IMEM_AW-1:0] load_addr_i,
    input  logic [31:0]            load_data_i,
    output logic                   retire_o,
    output logic [`RV_XLEN-1:0]    retire_pc_o,
    output logic [31:0]            retire_inst_o,
    output logic                   wb_en_o,
    output logic [4:0]             wb_addr_o,
    output logic [`RV_XLEN-1:0]    wb_data_o,
    output logic                   fault_o,
    output logic [`RV_XLEN-1:0]    fault_pc_o
);

    // ifu <-> sram read channel
    logic                ar_valid;
    logic [`RV_XLEN-1:0] ar_addr;
    logic                ar_ready;
    logic                r_valid;
    logic [31:0]         r_data;
    rv_bus_pkg::resp_e   r_resp;
    logic                r_ready;

    logic                ex_valid;
    logic [`RV_XLEN-1:0] pc;
    logic [31:0]         inst;
    logic [4:0]          raddr1, raddr2;
    logic [`RV_XLEN-1:0] rdata1, rdata2;
    logic [`RV_XLEN-1:0] op1, op2;
    rv_isa_pkg::alu_op_e alu_op;
    logic [`RV_XLEN-1:0] alu_result;
    logic                alu_eq;
    logic                rd_we;
    logic [4:0]          rd_addr;
    logic                is_jal;
    logic [`RV_XLEN-1:0] next_pc;
    logic                illegal;
    logic                reg_we;
    logic [`RV_XLEN-1:0] wb_data;

    inst_sram inst_sram_i (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .load_we_i(load_we_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
        .ar_valid_i(ar_valid), .ar_addr_i(ar_addr), .ar_ready_o(ar_ready),
        .r_ready_i(r_ready), .r_valid_o(r_valid), .r_data_o(r_data), .r_resp_o(r_resp)
    );

    rv_ifu rv_ifu_i (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .start_i(start_i),
        .ar_ready_i(ar_ready), .r_valid_i(r_valid), .r_data_i(r_data), .r_resp_i(r_resp),
        .next_pc_i(next_pc), .illegal_i(illegal),
        .ar_valid_o(ar_valid), .ar_addr_o(ar_addr), .r_ready_o(r_ready),
        .ex_valid_o(ex_valid), .pc_o(pc), .inst_o(inst), .fault_o(fault_o)
    );

    rv_idu rv_idu_i (
        .pc_i(pc), .inst_i(inst),
        .raddr1_o(raddr1), .raddr2_o(raddr2), .rdata1_i(rdata1), .rdata2_i(rdata2),
        .op1_o(op1), .op2_o(op2), .alu_op_o(alu_op),
        .alu_result_i(alu_result), .alu_eq_i(alu_eq),
        .rd_we_o(rd_we), .rd_addr_o(rd_addr), .is_jal_o(is_jal),
        .next_pc_o(next_pc), .illegal_o(illegal)
    );

    rv_exu rv_exu_i (
        .op1_i(op1), .op2_i(op2), .alu_op_i(alu_op),
        .result_o(alu_result), .eq_o(alu_eq)
    );

    rv_regs rv_regs_i (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .we_i(reg_we), .waddr_i(rd_addr), .wdata_i(wb_data),
        .raddr1_i(raddr1), .raddr2_i(raddr2), .rdata1_o(rdata1), .rdata2_o(rdata2)
    );

    // write-back merge, jal links pc+4
    assign wb_data = is_jal ? (pc + 64'd4) : alu_result;
    assign reg_we  = ex_valid && !illegal && rd_we && (rd_addr != 5'd0);

    assign retire_o      = ex_valid && !illegal;
    assign retire_pc_o   = pc;
    assign retire_inst_o = inst;
    assign wb_en_o       = reg_we;
    assign wb_addr_o     = rd_addr;
    assign wb_data_o     = wb_data;
    assign fault_pc_o    = pc;  // ifu holds pc once halted

endmodule

//--- tb/rv_core_sva.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core_sva (
    input logic                clk_i,
    input logic                arst_n_i,
    input logic                ar_valid_i,
    input logic                ar_ready_i,
    input logic [`RV_XLEN-1:0] ar_addr_i,
    input logic                r_valid_i,
    input logic                r_ready_i,
    input logic                retire_i,
    input logic                fault_i,
    input logic                wb_en_i,
    input logic [4:0]          wb_addr_i
);

    // request held with a stable address until accepted
    ar_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
        else $error("ar_valid dropped or ar_addr changed before ar_ready");

    r_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        r_valid_i && !r_ready_i |=> r_valid_i)
        else $error("r_valid fell without r_ready");

    retire_fault: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(retire_i && fault_i))
        else $error("retire_o and fault_o high in the same cycle");

    wb_not_x0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_en_i |-> wb_addr_i != 5'd0)
        else $error("wb_en_o asserted for x0");

endmodule

bind rv_core rv_core_sva rv_core_sva_i (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .ar_valid_i(ar_valid), .ar_ready_i(ar_ready), .ar_addr_i(ar_addr),
    .r_valid_i(r_valid), .r_ready_i(r_ready),
    .retire_i(retire_o), .fault_i(fault_o), .wb_en_i(wb_en_o), .wb_addr_i(wb_addr_o)
);

//--- tb/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core_tb;

    typedef struct {
        int                  run;
        logic [31:0]         inst;
        logic [`RV_XLEN-1:0] pc;
        logic                we;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] val;
        logic                flt;  // fault expected at pc
    } row_t;

    logic                   clk_i, arst_n_i, start_i, load_we_i;
    logic [`RV_IMEM_AW-1:0] load_addr_i;
    logic [31:0]            load_data_i, retire_inst_o;
    logic                   retire_o, wb_en_o, fault_o, armed;
    logic [4:0]             wb_addr_o;
    logic [`RV_XLEN-1:0]    retire_pc_o, wb_data_o, fault_pc_o, x1, x2;
    logic [11:0]            rnd;
    row_t                   tbl [$];
    int                     errors, checks, cyc, t0, limit;

    rv_core rv_core_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // watchdog, armed from each start pulse
    initial begin
        cyc = 0;
        do begin
            @(posedge clk_i);
            cyc++;
        end while (!armed || cyc - t0 <= limit);
        $display("TIMEOUT: no retire or fault within %0d cycles of start", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_val(input string name, input logic [`RV_XLEN-1:0] exp,
                             input logic [`RV_XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s expected %h got %h", name, exp, act);
        end
    endtask

    // one sram word per cycle, core must stay quiet meanwhile
    task automatic load_word(input logic [`RV_IMEM_AW-1:0] addr, input logic [31:0] data);
        check_val("retire_o/wb_en_o/fault_o", 64'd0, 64'({retire_o, wb_en_o, fault_o}));
        load_we_i   = 1'b1;
        load_addr_i = addr;
        load_data_i = data;
        @(negedge clk_i);
        load_we_i = 1'b0;
    endtask

    task automatic check_row(input row_t r);
        if (r.flt) begin
            check_val("fault_o", 64'd1, 64'(fault_o));
            check_val("fault_pc_o", r.pc, fault_pc_o);
        end else begin
            check_val("retire_o", 64'd1, 64'(retire_o));
            check_val("retire_pc_o", r.pc, retire_pc_o);
            check_val("retire_inst_o", 64'(r.inst), 64'(retire_inst_o));
            check_val("wb_en_o", 64'(r.we), 64'(wb_en_o));
            if (r.we) begin
                check_val("wb_addr_o", 64'(r.rd), 64'(wb_addr_o));
                check_val("wb_data_o", r.val, wb_data_o);
            end
        end
    endtask

    task automatic run_program(input int run, input string name);
        int nrun;
        int errs0;
        nrun  = 0;
        errs0 = errors;
        arst_n_i = 1'b0;
        repeat (3) @(negedge clk_i);
        arst_n_i = 1'b1;
        for (int a = 0; a < (1 << `RV_IMEM_AW); a++) begin
            load_word(a[`RV_IMEM_AW-1:0], {a[24:0], 7'h7f});  // illegal opcode everywhere
        end
        foreach (tbl[i]) begin
            if (tbl[i].run == run) begin
                nrun++;
                if (tbl[i].pc < 64'd256) load_word(tbl[i].pc[7:2], tbl[i].inst);
            end
        end
        t0    = cyc;
        limit = nrun * 3 + 50;
        armed = 1'b1;
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        foreach (tbl[i]) begin
            if (tbl[i].run == run) begin
                do @(negedge clk_i); while (!retire_o && !fault_o);
                check_row(tbl[i]);
            end
        end
        // halted until the next reset
        repeat (8) begin
            @(negedge clk_i);
            check_val("retire_o", 64'd0, 64'(retire_o));
            check_val("fault_o", 64'd1, 64'(fault_o));
        end
        armed = 1'b0;
        $display("%s: %0d rows, %0d errors", name, nrun, errors - errs0);
    endtask

    initial begin
        arst_n_i    = 1'b0;
        start_i     = 1'b0;
        load_we_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        armed  = 1'b0;
        errors = 0;
        checks = 0;
        t0     = 0;
        limit  = 0;
        void'($urandom(32'haa598ff9));
        rnd = 12'($urandom);
        x1  = 64'h123;
        x2  = {{52{rnd[11]}}, rnd};  // i-immediate is sign extended
        tbl.push_back(row_t'{0, 32'h12300093, 64'd0, 1'b1, 5'd1, x1, 1'b0});  // addi x1,x0,0x123
        tbl.push_back(row_t'{0, {rnd, 20'h00113}, 64'd4, 1'b1, 5'd2, x2, 1'b0});  // addi x2,x0
        tbl.push_back(row_t'{0, 32'h002081b3, 64'd8, 1'b1, 5'd3, x1 + x2, 1'b0});  // add
        tbl.push_back(row_t'{0, 32'h40208233, 64'd12, 1'b1, 5'd4, x1 - x2, 1'b0});  // sub
        tbl.push_back(row_t'{0, 32'h0020f2b3, 64'd16, 1'b1, 5'd5, x1 & x2, 1'b0});  // and
        tbl.push_back(row_t'{0, 32'h0020e333, 64'd20, 1'b1, 5'd6, x1 | x2, 1'b0});  // or
        tbl.push_back(row_t'{0, 32'h0020c3b3, 64'd24, 1'b1, 5'd7, x1 ^ x2, 1'b0});  // xor
        tbl.push_back(row_t'{0, 32'habcde437, 64'd28, 1'b1, 5'd8, 64'hffffffff_abcde000, 1'b0});
        tbl.push_back(row_t'{0, 32'h00508013, 64'd32, 1'b0, 5'd0, 64'd0, 1'b0});  // addi x0,x1,5
        tbl.push_back(row_t'{0, 32'h001004b3, 64'd36, 1'b1, 5'd9, x1, 1'b0});  // add x9,x0,x1
        tbl.push_back(row_t'{0, 32'h00008463, 64'd40, 1'b0, 5'd0, 64'd0, 1'b0});  // beq not taken
        tbl.push_back(row_t'{0, 32'h00318463, 64'd44, 1'b0, 5'd0, 64'd0, 1'b0});  // beq skips 48
        tbl.push_back(row_t'{0, 32'h00c0056f, 64'd52, 1'b1, 5'd10, 64'd56, 1'b0});  // jal to 64
        tbl.push_back(row_t'{0, 32'h0000000b, 64'd64, 1'b0, 5'd0, 64'd0, 1'b1});  // custom-0
        tbl.push_back(row_t'{1, 32'h100000ef, 64'd0, 1'b1, 5'd1, 64'd4, 1'b0});  // jal to 256
        tbl.push_back(row_t'{1, 32'h00000000, 64'd256, 1'b0, 5'd0, 64'd0, 1'b1});  // slverr
        run_program(0, "alu, x0, branch, jal, illegal opcode");
        run_program(1, "jal beyond sram, bus error");
        $display("tests 2, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_bus_pkg.sv
hw/inst_sram.sv
hw/rv_ifu.sv
hw/rv_idu.sv
hw/rv_exu.sv
hw/rv_regs.sv
hw/rv_core.sv
tb/rv_core_sva.sv
tb/rv_core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module rv_core_tb
out=$(./obj_dir/Vrv_core_tb)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"
